// File: sources.f
rtl/mmio_pkg.sv
rtl/dev_bus_if.sv
rtl/mmio_cntr.sv
rtl/uart_tx_dev.sv
rtl/clint_dev.sv
rtl/data_ram.sv
rtl/mmio_top.sv
tests/tb_mmio.sv

// File: tests/tb_mmio.sv
`timescale 1ns/1ps

module tb_mmio;

    localparam int ram_words  = 256;
    localparam int bit_clks   = 8;
    localparam int frame_clks = 10 * bit_clks;

    localparam logic [31:0] uart_data_addr   = {mmio_pkg::uart_region, 24'h0};
    localparam logic [31:0] uart_status_addr = {mmio_pkg::uart_region, 24'h4};
    localparam logic [31:0] clint_base       = {mmio_pkg::clint_region, 24'h0};

    logic         clk;
    logic         reset;
    logic         dreq_valid;
    logic         dreq_ready;
    logic [31:0]  dreq_addr;
    logic         dreq_wen;
    logic [31:0]  dreq_wdata;
    logic [3:0]   dreq_wmask;
    logic         dresp_valid;
    logic [31:0]  dresp_rdata;
    logic         dresp_error;
    logic         uart_tx;
    logic         mti_pending;

    mmio_top #(
        .ram_words    (ram_words),
        .clks_per_bit (bit_clks)
    ) UUT (
        .clk         (clk),
        .reset       (reset),
        .dreq_valid  (dreq_valid),
        .dreq_ready  (dreq_ready),
        .dreq_addr   (dreq_addr),
        .dreq_wen    (dreq_wen),
        .dreq_wdata  (dreq_wdata),
        .dreq_wmask  (dreq_wmask),
        .dresp_valid (dresp_valid),
        .dresp_rdata (dresp_rdata),
        .dresp_error (dresp_error),
        .uart_tx     (uart_tx),
        .mti_pending (mti_pending)
    );

    int           cyc = 0;        // posedge count
    int           errors = 0;
    int           checks = 0;
    int           tests = 0;
    int           resp_count = 0;
    logic [16:0]  lfsr = 17'd68962;

    // reference model state
    logic [31:0]  ram_model [ram_words];
    logic [63:0]  cmp_model = '1;
    longint       mtime_off = 0;
    logic         mtime_known = 1'b0;
    int           uart_start = -1000;
    int           ref_accept_edge;
    logic [7:0]   uart_bytes [$];

    // expected responses as {check data, error, rdata}
    logic [33:0]  exp_word [$];
    int           exp_edge [$];
    logic [33:0]  resp_word;
    int           resp_edge;
    logic [31:0]  last_rdata;

    int           e;
    int           e0;
    int           base;
    logic [31:0]  rd1;
    logic [31:0]  rd2;
    logic [7:0]   b1;
    logic [7:0]   b2;
    logic [7:0]   idx [8];
    logic [1:0]   kind;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[16] ^ lfsr[13];   // x^17 + x^14 + 1
        lfsr = {lfsr[15:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic logic uart_busy_at(input int at_edge);
        return (at_edge > uart_start) && (at_edge <= uart_start + frame_clks);
    endfunction

    // expected {check data, error, rdata} for a request transferred at at_edge
    function automatic logic [33:0] ref_access(input logic [31:0] addr, input logic wen,
                                               input logic [31:0] wdata, input logic [3:0] wmask,
                                               input int at_edge);
        logic [31:0] rdata;
        logic [63:0] mt;
        logic        err;
        logic        chk;
        int          w;
        rdata = '0;
        err = 1'b0;
        chk = !wen;
        ref_accept_edge = at_edge;
        mt = mtime_off + at_edge;
        if (addr[31:24] == mmio_pkg::uart_region) begin
            if (wen && addr[3:0] == mmio_pkg::uart_data_off) begin
                if (uart_busy_at(at_edge)) ref_accept_edge = uart_start + frame_clks + 1;
                uart_start = ref_accept_edge;
                uart_bytes.push_back(wdata[7:0]);
            end else if (addr[3:0] == mmio_pkg::uart_status_off) begin
                rdata = {31'b0, uart_busy_at(at_edge)};
            end
        end else if (addr[31:24] == mmio_pkg::clint_region) begin
            case (addr[3:0])
                mmio_pkg::clint_mtime_lo_off: begin
                    rdata = mt[31:0];
                    chk = chk && mtime_known;
                end
                mmio_pkg::clint_mtime_hi_off: begin
                    rdata = mt[63:32];
                    chk = chk && mtime_known;
                end
                mmio_pkg::clint_mtimecmp_lo_off: begin
                    rdata = cmp_model[31:0];
                    if (wen) cmp_model[31:0] = wdata;
                end
                mmio_pkg::clint_mtimecmp_hi_off: begin
                    rdata = cmp_model[63:32];
                    if (wen) cmp_model[63:32] = wdata;
                end
                default: rdata = '0;
            endcase
        end else if (addr[31:2] >= ram_words) begin
            err = 1'b1;   // fault leaves the ram untouched
            chk = 1'b1;
        end else begin
            w = int'(addr[31:2]);
            if (wen) begin
                for (int b = 0; b < 4; b++) begin
                    if (wmask[b]) ram_model[w][8*b +: 8] = wdata[8*b +: 8];
                end
            end else begin
                rdata = ram_model[w];
            end
        end
        return {chk, err, rdata};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic end_run();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        end_run();
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "FAILED");
    endtask

    // drive one request, return once it has transferred
    task automatic send_req(input logic [31:0] addr, input logic wen, input logic [31:0] wdata,
                            input logic [3:0] wmask, output int xfer_edge);
        int n;
        dreq_addr  = addr;
        dreq_wen   = wen;
        dreq_wdata = wdata;
        dreq_wmask = wmask;
        dreq_valid = 1'b1;
        n = 0;
        @(negedge clk);
        while (!dreq_ready) begin
            n++;
            if (n > 200) timeout_fail("dreq_ready");
            @(negedge clk);
        end
        xfer_edge = cyc + 1;
        exp_word.push_back(ref_access(addr, wen, wdata, wmask, xfer_edge));
        exp_edge.push_back(ref_accept_edge);
        @(posedge clk);
        #2;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge clk);
        while (exp_word.size() != 0) begin
            n++;
            if (n > 200) timeout_fail("outstanding responses");
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic do_req(input logic [31:0] addr, input logic wen, input logic [31:0] wdata,
                          input logic [3:0] wmask, output int xfer_edge);
        send_req(addr, wen, wdata, wmask, xfer_edge);
        dreq_valid = 1'b0;
        wait_drain();
    endtask

    task automatic wait_pending(input logic val, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (mti_pending !== val) begin
            n++;
            if (n > limit) timeout_fail("mti_pending");
            @(negedge clk);
        end
    endtask

    // mid-bit sampling after the start edge
    task automatic decode_frame();
        logic [7:0] b;
        logic [7:0] exp_b;
        int         n;
        n = 0;
        @(negedge clk);
        while (uart_tx !== 1'b0) begin
            n++;
            if (n > 400) timeout_fail("uart start bit");
            @(negedge clk);
        end
        repeat (bit_clks / 2) @(negedge clk);
        check_eq("uart_tx start bit", uart_tx, 1'b0);
        for (int i = 0; i < 8; i++) begin
            repeat (bit_clks) @(negedge clk);
            b[i] = uart_tx;
        end
        repeat (bit_clks) @(negedge clk);
        check_eq("uart_tx stop bit", uart_tx, 1'b1);
        if (uart_bytes.size() == 0) begin
            errors++;
            $display("uart frame seen with no byte written");
        end else begin
            exp_b = uart_bytes.pop_front();
            check_eq("uart_tx byte", b, exp_b);
        end
    endtask

    // response checker
    always @(negedge clk) begin
        if (!reset && dresp_valid) begin
            resp_count++;
            last_rdata = dresp_rdata;
            if (exp_word.size() == 0) begin
                errors++;
                $display("response arrived with no request outstanding");
            end else begin
                resp_word = exp_word.pop_front();
                resp_edge = exp_edge.pop_front();
                if (resp_word[33]) check_eq("dresp_rdata", dresp_rdata, resp_word[31:0]);
                check_eq("dresp_error", dresp_error, resp_word[32]);
                check_eq("dresp_valid cycle", cyc, resp_edge);
            end
        end
    end

    initial begin
        reset      = 1'b1;
        dreq_valid = 1'b0;
        dreq_addr  = '0;
        dreq_wen   = 1'b0;
        dreq_wdata = '0;
        dreq_wmask = '0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        e0 = errors;
        @(negedge clk);
        check_eq("dreq_ready", dreq_ready, 1'b1);
        check_eq("dresp_valid", dresp_valid, 1'b0);
        check_eq("uart_tx", uart_tx, 1'b1);
        check_eq("mti_pending", mti_pending, 1'b0);
        @(posedge clk);
        #2;
        report_test("reset state", e0);

        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            idx[i] = 8'(rand_bits(8));
            do_req({22'b0, idx[i], 2'b00}, 1'b1, rand_bits(32), 4'hf, e);
            do_req({22'b0, idx[i], 2'b00}, 1'b1, rand_bits(32), 4'(rand_bits(4)), e);
        end
        for (int i = 0; i < 8; i++) do_req({22'b0, idx[i], 2'b00}, 1'b0, '0, '0, e);
        report_test("ram read-back", e0);

        e0 = errors;
        do_req(32'(ram_words * 4) + {22'b0, idx[0], 2'b00}, 1'b1, rand_bits(32), 4'hf, e);
        do_req(32'(ram_words * 4) + {22'b0, idx[0], 2'b00}, 1'b0, '0, '0, e);
        do_req(32'h4000_0000 | {22'b0, idx[0], 2'b00}, 1'b1, rand_bits(32), 4'hf, e);
        do_req({22'b0, idx[0], 2'b00}, 1'b0, '0, '0, e);   // alias unchanged
        report_test("ram range fault", e0);

        e0 = errors;
        b1 = 8'(rand_bits(8));
        b2 = 8'(rand_bits(8));
        fork
            begin
                decode_frame();
                decode_frame();
            end
            begin
                do_req(uart_data_addr, 1'b1, {24'b0, b1}, 4'h1, e);
                do_req(uart_status_addr, 1'b0, '0, '0, e);
                check_eq("uart busy", last_rdata, 32'h1);
                do_req(uart_data_addr, 1'b1, {24'b0, b2}, 4'h1, e);   // held off
            end
        join
        @(posedge clk);
        #2;
        report_test("uart frame", e0);

        e0 = errors;
        do_req(clint_base, 1'b0, '0, '0, e);
        rd1 = last_rdata;
        mtime_off = longint'(rd1) - e;
        mtime_known = 1'b1;
        do_req(clint_base, 1'b0, '0, '0, e);
        rd2 = last_rdata;
        check_eq("mtime low increasing", rd2 > rd1, 1'b1);
        do_req(clint_base + 32'hc, 1'b1, 32'h0, 4'hf, e);
        do_req(clint_base + 32'h8, 1'b1, rd2 + 32'd20, 4'hf, e);
        check_eq("mti_pending", mti_pending, 1'b0);
        wait_pending(1'b1, 100);
        @(posedge clk);
        #2;
        do_req(clint_base + 32'hc, 1'b1, 32'hffff_ffff, 4'hf, e);
        wait_pending(1'b0, 4);
        @(posedge clk);
        #2;
        report_test("timer", e0);

        e0 = errors;
        base = resp_count;
        for (int i = 0; i < 24; i++) begin
            kind = 2'(rand_bits(2));
            case (kind)
                2'd0: send_req({22'b0, idx[3'(rand_bits(3))], 2'b00}, 1'b0, '0, '0, e);
                2'd1: send_req({22'b0, idx[3'(rand_bits(3))], 2'b00}, 1'b1, rand_bits(32),
                               4'(rand_bits(4)), e);
                2'd2: send_req(uart_status_addr, 1'b0, '0, '0, e);
                default: send_req(clint_base + {28'b0, 2'(rand_bits(2)), 2'b00}, 1'b0, '0, '0, e);
            endcase
        end
        dreq_valid = 1'b0;
        wait_drain();
        check_eq("response count", resp_count - base, 24);
        report_test("back-to-back", e0);

        end_run();
    end

endmodule

// File: rtl/mmio_top.sv
`timescale 1ns/1ps

module mmio_top #(
    parameter int ram_words    = 256,
    parameter int clks_per_bit = 8
) (
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         dreq_valid,
    output logic                         dreq_ready,
    input  mmio_pkg::mmio_addr_t         dreq_addr,
    input  logic                         dreq_wen,
    input  logic [mmio_pkg::xlen-1:0]    dreq_wdata,
    input  logic [mmio_pkg::xlen/8-1:0]  dreq_wmask,

    output logic                         dresp_valid,
    output logic [mmio_pkg::xlen-1:0]    dresp_rdata,
    output logic                         dresp_error,

    output logic                         uart_tx,
    output logic                         mti_pending
);

    dev_bus_if mem_bus ();
    dev_bus_if uart_bus ();
    dev_bus_if clint_bus ();

    mmio_cntr u_cntr (
        .clk         (clk),
        .reset       (reset),
        .dreq_valid  (dreq_valid),
        .dreq_ready  (dreq_ready),
        .dreq_addr   (dreq_addr),
        .dreq_wen    (dreq_wen),
        .dreq_wdata  (dreq_wdata),
        .dreq_wmask  (dreq_wmask),
        .dresp_valid (dresp_valid),
        .dresp_rdata (dresp_rdata),
        .dresp_error (dresp_error),
        .mem_bus     (mem_bus),
        .uart_bus    (uart_bus),
        .clint_bus   (clint_bus)
    );

    data_ram #(.ram_words(ram_words)) u_ram (
        .clk   (clk),
        .reset (reset),
        .bus   (mem_bus)
    );

    uart_tx_dev #(.clks_per_bit(clks_per_bit)) u_uart (
        .clk     (clk),
        .reset   (reset),
        .bus     (uart_bus),
        .uart_tx (uart_tx)
    );

    clint_dev u_clint (
        .clk         (clk),
        .reset       (reset),
        .bus         (clint_bus),
        .mti_pending (mti_pending)
    );

endmodule

// File: rtl/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int ram_words = 256
) (
    input  logic       clk,
    input  logic       reset,
    dev_bus_if.device  bus
);

    localparam int idx_w = (ram_words > 1) ? $clog2(ram_words) : 1;

    logic [mmio_pkg::xlen-1:0]  mem [ram_words];
    logic [mmio_pkg::xlen-3:0]  word_addr;
    logic [idx_w-1:0]           idx;
    logic                       in_range;

    assign word_addr     = bus.addr.raw[mmio_pkg::xlen-1:2];
    assign idx           = word_addr[idx_w-1:0];
    assign in_range      = word_addr < (mmio_pkg::xlen-2)'(ram_words);
    assign bus.req_ready = 1'b1;

    always_ff @(posedge clk) begin
        if (bus.req_valid && bus.wen && in_range) begin
            for (int b = 0; b < mmio_pkg::xlen/8; b++) begin
                if (bus.wmask[b]) mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.req_valid) begin
            bus.rdata <= in_range ? mem[idx] : '0;  // old word on a write
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.resp_valid <= 1'b0;
            bus.error      <= 1'b0;
        end else begin
            bus.resp_valid <= bus.req_valid;
            if (bus.req_valid) bus.error <= !in_range;
        end
    end

endmodule

// File: rtl/clint_dev.sv
`timescale 1ns/1ps

module clint_dev (
    input  logic       clk,
    input  logic       reset,
    dev_bus_if.device  bus,
    output logic       mti_pending
);

    logic [63:0]  mtime;
    logic [63:0]  mtimecmp;
    logic [3:0]   reg_off;
    logic         accept;

    assign reg_off       = bus.addr.fields.offset[3:0];
    assign bus.req_ready = 1'b1;
    assign accept        = bus.req_valid;
    assign bus.error     = 1'b0;

    always_ff @(posedge clk) begin
        if (reset) begin
            mtime       <= '0;
            mtimecmp    <= '1;   // no interrupt until programmed
            mti_pending <= 1'b0;
        end else begin
            mtime       <= mtime + 64'd1;
            mti_pending <= (mtime >= mtimecmp);
            if (accept && bus.wen) begin
                case (reg_off)
                    mmio_pkg::clint_mtimecmp_lo_off: mtimecmp[31:0]  <= bus.wdata;
                    mmio_pkg::clint_mtimecmp_hi_off: mtimecmp[63:32] <= bus.wdata;
                    default: ;  // mtime is read only
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.resp_valid <= 1'b0;
        end else begin
            bus.resp_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            case (reg_off)
                mmio_pkg::clint_mtime_lo_off:    bus.rdata <= mtime[31:0];
                mmio_pkg::clint_mtime_hi_off:    bus.rdata <= mtime[63:32];
                mmio_pkg::clint_mtimecmp_lo_off: bus.rdata <= mtimecmp[31:0];
                mmio_pkg::clint_mtimecmp_hi_off: bus.rdata <= mtimecmp[63:32];
                default:                         bus.rdata <= '0;
            endcase
        end
    end

endmodule

// File: rtl/uart_tx_dev.sv
`timescale 1ns/1ps

module uart_tx_dev #(
    parameter int clks_per_bit = 8
) (
    input  logic       clk,
    input  logic       reset,
    dev_bus_if.device  bus,
    output logic       uart_tx
);

    localparam int frame_bits = 10;
    localparam int baud_w     = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

    logic [frame_bits-1:0]          shreg;     // stop, data, start
    logic [3:0]                     bit_cnt;   // bits left in frame
    logic [baud_w-1:0]              baud_cnt;
    logic                           busy;
    logic                           is_data_wr;
    logic                           is_status;
    logic                           accept;

    assign busy       = (bit_cnt != 4'd0);
    assign is_data_wr = bus.wen && (bus.addr.fields.offset[3:0] == mmio_pkg::uart_data_off);
    assign is_status  = bus.addr.fields.offset[3:0] == mmio_pkg::uart_status_off;

    // only a data write has to wait for the line
    assign bus.req_ready = !(is_data_wr && busy);
    assign accept        = bus.req_valid && bus.req_ready;
    assign bus.error     = 1'b0;
    assign uart_tx       = shreg[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            shreg    <= '1;   // idle line
            bit_cnt  <= 4'd0;
            baud_cnt <= '0;
        end else if (accept && is_data_wr) begin
            shreg    <= {1'b1, bus.wdata[7:0], 1'b0};
            bit_cnt  <= 4'(frame_bits);
            baud_cnt <= '0;
        end else if (busy) begin
            if (baud_cnt == baud_w'(clks_per_bit - 1)) begin
                baud_cnt <= '0;
                shreg    <= {1'b1, shreg[frame_bits-1:1]};
                bit_cnt  <= bit_cnt - 4'd1;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.resp_valid <= 1'b0;
        end else begin
            bus.resp_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (is_status && !bus.wen) begin
                bus.rdata <= {{(mmio_pkg::xlen-1){1'b0}}, busy};
            end else begin
                bus.rdata <= '0;
            end
        end
    end

endmodule

// File: rtl/mmio_cntr.sv
`timescale 1ns/1ps

module mmio_cntr (
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         dreq_valid,
    output logic                         dreq_ready,
    input  mmio_pkg::mmio_addr_t         dreq_addr,
    input  logic                         dreq_wen,
    input  logic [mmio_pkg::xlen-1:0]    dreq_wdata,
    input  logic [mmio_pkg::xlen/8-1:0]  dreq_wmask,

    output logic                         dresp_valid,
    output logic [mmio_pkg::xlen-1:0]    dresp_rdata,
    output logic                         dresp_error,

    dev_bus_if.host                      mem_bus,
    dev_bus_if.host                      uart_bus,
    dev_bus_if.host                      clint_bus
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ready,
        st_wait_resp
    } state_t;

    function automatic mmio_pkg::region_t decode_region(input mmio_pkg::mmio_addr_t a);
        case (a.fields.region)
            mmio_pkg::uart_region:  return mmio_pkg::region_uart;
            mmio_pkg::clint_region: return mmio_pkg::region_clint;
            default:                return mmio_pkg::region_mem;
        endcase
    endfunction

    state_t                       state;

    // latched copy of the accepted request
    mmio_pkg::mmio_addr_t         s_addr;
    logic                         s_wen;
    logic [mmio_pkg::xlen-1:0]    s_wdata;
    logic [mmio_pkg::xlen/8-1:0]  s_wmask;
    mmio_pkg::region_t            s_region;

    mmio_pkg::region_t            live_region;
    mmio_pkg::region_t            req_region;
    mmio_pkg::mmio_addr_t         req_addr;
    logic                         req_wen;
    logic [mmio_pkg::xlen-1:0]    req_wdata;
    logic [mmio_pkg::xlen/8-1:0]  req_wmask;
    logic                         cmd_ready;
    logic                         cmd_start;
    logic                         sel_resp_valid;
    logic                         s_done;

    assign live_region = decode_region(dreq_addr);

    // replay from the latch while the target holds us off
    assign req_region = (state == st_wait_ready) ? s_region : live_region;
    assign req_addr   = (state == st_wait_ready) ? s_addr   : dreq_addr;
    assign req_wen    = (state == st_wait_ready) ? s_wen    : dreq_wen;
    assign req_wdata  = (state == st_wait_ready) ? s_wdata  : dreq_wdata;
    assign req_wmask  = (state == st_wait_ready) ? s_wmask  : dreq_wmask;

    always_comb begin
        case (req_region)
            mmio_pkg::region_uart:  cmd_ready = uart_bus.req_ready;
            mmio_pkg::region_clint: cmd_ready = clint_bus.req_ready;
            default:                cmd_ready = mem_bus.req_ready;
        endcase
        case (s_region)
            mmio_pkg::region_uart:  sel_resp_valid = uart_bus.resp_valid;
            mmio_pkg::region_clint: sel_resp_valid = clint_bus.resp_valid;
            default:                sel_resp_valid = mem_bus.resp_valid;
        endcase
        case (s_region)
            mmio_pkg::region_uart:  dresp_rdata = uart_bus.rdata;
            mmio_pkg::region_clint: dresp_rdata = clint_bus.rdata;
            default:                dresp_rdata = mem_bus.rdata;
        endcase
    end

    assign s_done     = (state == st_wait_resp) && sel_resp_valid;
    assign dreq_ready = (state == st_idle) || s_done;
    assign cmd_start  = (state == st_wait_ready) || (dreq_ready && dreq_valid);

    assign dresp_valid = s_done;
    assign dresp_error = (s_region == mmio_pkg::region_mem) ? mem_bus.error : 1'b0; // devices never fault

    assign mem_bus.req_valid   = cmd_start && (req_region == mmio_pkg::region_mem);
    assign uart_bus.req_valid  = cmd_start && (req_region == mmio_pkg::region_uart);
    assign clint_bus.req_valid = cmd_start && (req_region == mmio_pkg::region_clint);

    assign mem_bus.addr    = req_addr;
    assign mem_bus.wen     = req_wen;
    assign mem_bus.wdata   = req_wdata;
    assign mem_bus.wmask   = req_wmask;
    assign uart_bus.addr   = req_addr;
    assign uart_bus.wen    = req_wen;
    assign uart_bus.wdata  = req_wdata;
    assign uart_bus.wmask  = req_wmask;
    assign clint_bus.addr  = req_addr;
    assign clint_bus.wen   = req_wen;
    assign clint_bus.wdata = req_wdata;
    assign clint_bus.wmask = req_wmask;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_wait_ready: if (cmd_ready) state <= st_wait_resp;
                default: begin
                    if (dreq_ready && dreq_valid) begin
                        state <= cmd_ready ? st_wait_resp : st_wait_ready;
                    end else if (state == st_idle || s_done) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dreq_ready && dreq_valid) begin
            s_addr   <= dreq_addr;
            s_wen    <= dreq_wen;
            s_wdata  <= dreq_wdata;
            s_wmask  <= dreq_wmask;
            s_region <= live_region;
        end
    end

endmodule

// File: rtl/dev_bus_if.sv
`timescale 1ns/1ps

interface dev_bus_if;

    logic                         req_valid;
    logic                         req_ready;
    mmio_pkg::mmio_addr_t         addr;
    logic                         wen;
    logic [mmio_pkg::xlen-1:0]    wdata;
    logic [mmio_pkg::xlen/8-1:0]  wmask;  // one bit per byte

    logic                         resp_valid;  // one pulse per request
    logic [mmio_pkg::xlen-1:0]    rdata;
    logic                         error;

    modport host (
        output req_valid, addr, wen, wdata, wmask,
        input  req_ready, resp_valid, rdata, error
    );

    modport device (
        input  req_valid, addr, wen, wdata, wmask,
        output req_ready, resp_valid, rdata, error
    );

endinterface

// File: rtl/mmio_pkg.sv
package mmio_pkg;

    localparam int xlen = 32;

    // byte address, seen whole or as {region, offset}
    typedef union packed {
        logic [xlen-1:0] raw;
        struct packed {
            logic [7:0]  region;
            logic [23:0] offset;
        } fields;
    } mmio_addr_t;

    // target select inside the router
    typedef enum logic [1:0] {
        region_mem,
        region_uart,
        region_clint
    } region_t;

    // address map, everything else is memory
    localparam logic [7:0] uart_region  = 8'h10;
    localparam logic [7:0] clint_region = 8'h02;

    // uart registers
    localparam logic [3:0] uart_data_off   = 4'h0;
    localparam logic [3:0] uart_status_off = 4'h4;

    // clint registers
    localparam logic [3:0] clint_mtime_lo_off    = 4'h0;
    localparam logic [3:0] clint_mtime_hi_off    = 4'h4;
    localparam logic [3:0] clint_mtimecmp_lo_off = 4'h8;
    localparam logic [3:0] clint_mtimecmp_hi_off = 4'hc;

endpackage
